//--- hw/draw_pkg.sv
// Types shared by the compositing datapath, frame control and testbench
package draw_pkg;

    // RGB332 pixel colour
    // Bits 7:5 red, 4:2 green, 1:0 blue
    typedef logic [7:0] rgb_t;

    // Frame tracking states
    // No report is possible until one full frame has been seen
    typedef enum logic {
        FRAME_WAIT_FIRST = 1'b0,
        FRAME_ACTIVE     = 1'b1
    } frame_state_e;

    // Width of the completed-frame counter
    localparam int FRAME_COUNT_WIDTH = 8;

endpackage

//--- hw/overlap_if.sv
`timescale 1ns/10ps

// Per-pixel priority and overlap results
// Produced by check_overlap, consumed by the colour mux and the collision tracker
interface overlap_if #(
    parameter int OBJECT_AMOUNT       = 4,
    parameter int OBJECT_AMOUNT_WIDTH = 2
) ();

    // Same cycle as the draw requests
    logic                             any_dr;
    logic [OBJECT_AMOUNT_WIDTH - 1:0] first_object_index;

    // One pixel behind the draw requests
    logic                             overlap;
    logic [OBJECT_AMOUNT - 1:0]       active_q;

    modport source (
        output any_dr,
        output first_object_index,
        output overlap,
        output active_q
    );

    // Colour selection only needs the winner
    modport pixel_sink (
        input any_dr,
        input first_object_index
    );

    // Collision tracking only needs the registered results
    modport collision_sink (
        input overlap,
        input active_q
    );

endinterface

//--- hw/check_overlap.sv
`timescale 1ns/10ps

module check_overlap #(
    parameter int OBJECT_AMOUNT       = 4,
    parameter int OBJECT_AMOUNT_WIDTH = 2
) (
    input  logic                       clk,
    input  logic                       resetN,
    // Not used by this block, kept for pin compatibility
    input  logic                       startOfFrame,
    input  logic [OBJECT_AMOUNT - 1:0] draw_request,
    input  logic [OBJECT_AMOUNT - 1:0] object_deactivated,
    overlap_if.source                  ovl
);

    logic [OBJECT_AMOUNT - 1:0]       active;
    logic [OBJECT_AMOUNT_WIDTH - 1:0] first_index;
    logic [OBJECT_AMOUNT_WIDTH - 1:0] last_index;
    logic                             any_active;

    // A request only counts if the object is still alive
    assign active = draw_request & ~object_deactivated;

    // Lowest active index wins
    // Scan downward so the lowest match is written last
    always_comb begin
        first_index = '0;
        any_active  = 1'b0;
        for (int j = OBJECT_AMOUNT - 1; j >= 0; j--) begin
            if (active[j]) begin
                first_index = OBJECT_AMOUNT_WIDTH'(j);
                any_active  = 1'b1;
            end
        end
    end

    // Highest active index
    // Scan upward so the highest match is written last
    always_comb begin
        last_index = '0;
        for (int i = 0; i < OBJECT_AMOUNT; i++) begin
            if (active[i]) begin
                last_index = OBJECT_AMOUNT_WIDTH'(i);
            end
        end
    end

    assign ovl.any_dr             = any_active;
    assign ovl.first_object_index = first_index;

    // First and last differ only with two or more active requesters
    // No requester and a single requester both give equal indices
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            ovl.overlap <= 1'b0;
        end else begin
            ovl.overlap <= (first_index != last_index);
        end
    end

    // Mask of the previous pixel, lines up with overlap
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            ovl.active_q <= '0;
        end else begin
            ovl.active_q <= active;
        end
    end

endmodule

//--- hw/draw_priority_mux.sv
`timescale 1ns/10ps

module draw_priority_mux import draw_pkg::*; #(
    parameter int OBJECT_AMOUNT = 4
) (
    input  logic          clk,
    input  logic          resetN,
    input  rgb_t          object_rgb [OBJECT_AMOUNT],
    input  rgb_t          background_rgb,
    overlap_if.pixel_sink ovl,
    output rgb_t          rgb_out
);

    rgb_t pixel_rgb;

    // Winner colour, or background when nothing active is drawn here
    always_comb begin
        if (ovl.any_dr) begin
            pixel_rgb = object_rgb[ovl.first_object_index];
        end else begin
            pixel_rgb = background_rgb;
        end
    end

    // One register stage
    // Keeps the colour aligned with the registered overlap flag
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            rgb_out <= '0;
        end else begin
            rgb_out <= pixel_rgb;
        end
    end

endmodule

//--- hw/collision_tracker.sv
`timescale 1ns/10ps

module collision_tracker #(
    parameter int OBJECT_AMOUNT = 4
) (
    input  logic                       clk,
    input  logic                       resetN,
    // End of frame strobe from frame_control
    input  logic                       commit,
    overlap_if.collision_sink          ovl,
    output logic [OBJECT_AMOUNT - 1:0] collision_mask,
    output logic                       collision_valid
);

    logic [OBJECT_AMOUNT - 1:0] frame_acc;
    logic [OBJECT_AMOUNT - 1:0] pixel_hits;
    logic [OBJECT_AMOUNT - 1:0] frame_hits;

    // Objects involved in the overlap seen this cycle
    assign pixel_hits = ovl.overlap ? ovl.active_q : '0;

    // Current cycle still belongs to the frame being closed
    assign frame_hits = frame_acc | pixel_hits;

    // Frame accumulator
    // Restarts empty on commit
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            frame_acc <= '0;
        end else if (commit) begin
            frame_acc <= '0;
        end else begin
            frame_acc <= frame_hits;
        end
    end

    // Report register
    // Mask holds until the next commit
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            collision_mask  <= '0;
            collision_valid <= 1'b0;
        end else begin
            collision_valid <= commit;
            if (commit) begin
                collision_mask <= frame_hits;
            end
        end
    end

endmodule

//--- hw/frame_control.sv
`timescale 1ns/10ps

module frame_control import draw_pkg::*; (
    input  logic                           clk,
    input  logic                           resetN,
    input  logic                           startOfFrame,
    // Close the current frame report
    output logic                           commit,
    output logic [FRAME_COUNT_WIDTH - 1:0] frame_count
);

    frame_state_e state;

    // Report only once a full frame lies behind us
    // The first strobe after reset only opens a frame
    assign commit = startOfFrame && (state == FRAME_ACTIVE);

    // State register
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            state <= FRAME_WAIT_FIRST;
        end else begin
            case (state)
                FRAME_WAIT_FIRST: begin
                    if (startOfFrame) begin
                        state <= FRAME_ACTIVE;
                    end
                end
                FRAME_ACTIVE: begin
                    // Stay here until reset
                    state <= FRAME_ACTIVE;
                end
                default: begin
                    state <= FRAME_WAIT_FIRST;
                end
            endcase
        end
    end

    // Completed frames, wraps naturally at 8 bits
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            frame_count <= '0;
        end else if (commit) begin
            frame_count <= frame_count + 1'b1;
        end
    end

endmodule

//--- hw/object_draw_top.sv
`timescale 1ns/10ps

module object_draw_top import draw_pkg::*; #(
    parameter int OBJECT_AMOUNT       = 4,
    parameter int OBJECT_AMOUNT_WIDTH = 2
) (
    input  logic                           clk,
    input  logic                           resetN,
    input  logic                           startOfFrame,
    input  logic [OBJECT_AMOUNT - 1:0]     draw_request,
    input  logic [OBJECT_AMOUNT - 1:0]     object_deactivated,
    input  rgb_t                           object_rgb [OBJECT_AMOUNT],
    input  rgb_t                           background_rgb,

    output rgb_t                           rgb_out,
    output logic                           pixel_overlap,
    output logic [OBJECT_AMOUNT - 1:0]     collision_mask,
    output logic                           collision_valid,
    output logic [FRAME_COUNT_WIDTH - 1:0] frame_count
);

    // Commit strobe between frame control and the tracker
    logic commit;

    // Priority and overlap results of the current pixel
    overlap_if #(
        .OBJECT_AMOUNT       (OBJECT_AMOUNT),
        .OBJECT_AMOUNT_WIDTH (OBJECT_AMOUNT_WIDTH)
    ) u_ovl ();

    // Priority search and overlap detection
    // Its frame strobe input is left open
    check_overlap #(
        .OBJECT_AMOUNT       (OBJECT_AMOUNT),
        .OBJECT_AMOUNT_WIDTH (OBJECT_AMOUNT_WIDTH)
    ) u_check_overlap (
        .clk                (clk),
        .resetN             (resetN),
        .startOfFrame       (),
        .draw_request       (draw_request),
        .object_deactivated (object_deactivated),
        .ovl                (u_ovl.source)
    );

    // Colour output, one cycle behind the inputs
    draw_priority_mux #(
        .OBJECT_AMOUNT (OBJECT_AMOUNT)
    ) u_draw_priority_mux (
        .clk            (clk),
        .resetN         (resetN),
        .object_rgb     (object_rgb),
        .background_rgb (background_rgb),
        .ovl            (u_ovl.pixel_sink),
        .rgb_out        (rgb_out)
    );

    // Per-frame collision mask
    collision_tracker #(
        .OBJECT_AMOUNT (OBJECT_AMOUNT)
    ) u_collision_tracker (
        .clk             (clk),
        .resetN          (resetN),
        .commit          (commit),
        .ovl             (u_ovl.collision_sink),
        .collision_mask  (collision_mask),
        .collision_valid (collision_valid)
    );

    // Frame boundaries and frame counter
    frame_control u_frame_control (
        .clk          (clk),
        .resetN       (resetN),
        .startOfFrame (startOfFrame),
        .commit       (commit),
        .frame_count  (frame_count)
    );

    assign pixel_overlap = u_ovl.overlap;

endmodule

//--- testbench/object_draw_checker.sv
`timescale 1ns/10ps

module object_draw_checker import draw_pkg::*; #(
    parameter int OBJECT_AMOUNT = 4
) (
    input logic                       clk,
    input logic                       resetN,
    input logic                       collision_valid,
    input logic                       pixel_overlap,
    input logic [OBJECT_AMOUNT - 1:0] draw_request,
    input logic [OBJECT_AMOUNT - 1:0] object_deactivated,
    input rgb_t                       rgb_out,
    input rgb_t                       background_rgb,
    input frame_state_e               state
);

    logic [OBJECT_AMOUNT - 1:0] active;

    assign active = draw_request & ~object_deactivated;

    // Report is a single-cycle pulse
    valid_one_cycle: assert property (@(posedge clk) disable iff (!resetN)
        collision_valid |=> !collision_valid)
        else $error("collision_valid stayed high for two cycles");

    // Overlap needs two live requesters one pixel earlier
    overlap_needs_two: assert property (@(posedge clk) disable iff (!resetN)
        pixel_overlap && $past(resetN) |-> $countones($past(active)) >= 2)
        else $error("pixel_overlap without two active requests");

    // No report before a full frame exists
    // The strobe that raised the pulse must have seen the active state
    no_report_first_frame: assert property (@(posedge clk) disable iff (!resetN)
        collision_valid |-> $past(state) != FRAME_WAIT_FIRST)
        else $error("collision_valid while waiting for the first frame");

    // Empty pixel shows the background
    background_when_idle: assert property (@(posedge clk) disable iff (!resetN)
        $past(resetN) && ($past(active) == '0) |-> rgb_out == $past(background_rgb))
        else $error("rgb_out is not the background on an empty pixel");

endmodule

bind object_draw_top object_draw_checker #(
    .OBJECT_AMOUNT (OBJECT_AMOUNT)
) u_object_draw_checker (
    .clk                (clk),
    .resetN             (resetN),
    .collision_valid    (collision_valid),
    .pixel_overlap      (pixel_overlap),
    .draw_request       (draw_request),
    .object_deactivated (object_deactivated),
    .rgb_out            (rgb_out),
    .background_rgb     (background_rgb),
    .state              (u_frame_control.state)
);

//--- testbench/object_draw_tb.sv
`timescale 1ns/10ps

module object_draw_tb import draw_pkg::*; ();

    localparam int    OBJECT_AMOUNT       = 4;
    localparam int    OBJECT_AMOUNT_WIDTH = 2;
    localparam int    CLK_PERIOD          = 40;
    localparam int    MAX_LINES           = 256;
    localparam string PATTERNS_FILE       = "testbench/draw_patterns.txt";

    // Fixed object colours, RGB332
    localparam rgb_t COLOUR_OBJ0       = 8'hE0;
    localparam rgb_t COLOUR_OBJ1       = 8'h1C;
    localparam rgb_t COLOUR_OBJ2       = 8'h03;
    localparam rgb_t COLOUR_OBJ3       = 8'hFC;
    localparam rgb_t COLOUR_BACKGROUND = 8'h49;

    logic                           clk;
    logic                           resetN;
    logic                           startOfFrame;
    logic [OBJECT_AMOUNT - 1:0]     draw_request;
    logic [OBJECT_AMOUNT - 1:0]     object_deactivated;
    rgb_t                           object_rgb [OBJECT_AMOUNT];
    rgb_t                           background_rgb;
    rgb_t                           rgb_out;
    logic                           pixel_overlap;
    logic [OBJECT_AMOUNT - 1:0]     collision_mask;
    logic                           collision_valid;
    logic [FRAME_COUNT_WIDTH - 1:0] frame_count;

    // One entry per pattern line
    logic                       pat_sof    [MAX_LINES];
    logic [OBJECT_AMOUNT - 1:0] pat_dr     [MAX_LINES];
    logic [OBJECT_AMOUNT - 1:0] pat_deact  [MAX_LINES];
    rgb_t                       pat_rgb    [MAX_LINES];
    logic                       pat_ovl    [MAX_LINES];
    logic                       pat_report [MAX_LINES];
    logic [OBJECT_AMOUNT - 1:0] pat_mask   [MAX_LINES];

    int                             n_lines;
    logic                           patterns_loaded;
    // Reported mask holds between reports
    logic [OBJECT_AMOUNT - 1:0]     exp_mask;
    logic [FRAME_COUNT_WIDTH - 1:0] exp_frames;

    object_draw_top #(
        .OBJECT_AMOUNT       (OBJECT_AMOUNT),
        .OBJECT_AMOUNT_WIDTH (OBJECT_AMOUNT_WIDTH)
    ) u_object_draw_top (
        .clk                (clk),
        .resetN             (resetN),
        .startOfFrame       (startOfFrame),
        .draw_request       (draw_request),
        .object_deactivated (object_deactivated),
        .object_rgb         (object_rgb),
        .background_rgb     (background_rgb),
        .rgb_out            (rgb_out),
        .pixel_overlap      (pixel_overlap),
        .collision_mask     (collision_mask),
        .collision_valid    (collision_valid),
        .frame_count        (frame_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1, "Stopped at the first mismatch");
    endtask

    task automatic check_rgb(input string name, input rgb_t expected, input rgb_t actual);
        if (actual !== expected) begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("** Error %s: expected %b, actual %b", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_mask(input string name, input logic [OBJECT_AMOUNT - 1:0] expected,
                              input logic [OBJECT_AMOUNT - 1:0] actual);
        if (actual !== expected) begin
            $display("** Error %s: expected %b, actual %b", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_count(input string name,
                               input logic [FRAME_COUNT_WIDTH - 1:0] expected,
                               input logic [FRAME_COUNT_WIDTH - 1:0] actual);
        if (actual !== expected) begin
            $display("** Error %s: expected %0d, actual %0d", name, expected, actual);
            abort_run();
        end
    endtask

    // Present one pixel on the rising edge
    task automatic apply_line(input int idx);
        startOfFrame       <= pat_sof[idx];
        draw_request       <= pat_dr[idx];
        object_deactivated <= pat_deact[idx];
    endtask

    task automatic apply_idle();
        startOfFrame       <= 1'b0;
        draw_request       <= '0;
        object_deactivated <= '0;
    endtask

    // Outputs for a pixel, one clock after it was sampled
    task automatic verify_line(input int idx);
        string tag;
        tag = $sformatf("pattern %0d", idx + 1);
        // A report closes a frame, so the count steps with it
        if (pat_report[idx]) begin
            exp_mask   = pat_mask[idx];
            exp_frames = exp_frames + 1'b1;
        end
        check_rgb({tag, " rgb_out"}, pat_rgb[idx], rgb_out);
        check_bit({tag, " pixel_overlap"}, pat_ovl[idx], pixel_overlap);
        check_bit({tag, " collision_valid"}, pat_report[idx], collision_valid);
        check_mask({tag, " collision_mask"}, exp_mask, collision_mask);
        check_count({tag, " frame_count"}, exp_frames, frame_count);
    endtask

    initial begin
        int               fd;
        int               code;
        logic [8*256-1:0] skip_buf;
        // All inputs idle, reset held
        resetN             = 1'b0;
        startOfFrame       = 1'b0;
        draw_request       = '0;
        object_deactivated = '0;
        object_rgb[0]      = COLOUR_OBJ0;
        object_rgb[1]      = COLOUR_OBJ1;
        object_rgb[2]      = COLOUR_OBJ2;
        object_rgb[3]      = COLOUR_OBJ3;
        background_rgb     = COLOUR_BACKGROUND;
        n_lines            = 0;
        patterns_loaded    = 1'b0;
        exp_mask           = '0;
        exp_frames         = '0;

        fd = $fopen(PATTERNS_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the patterns file %s", PATTERNS_FILE);
            $display("Checks failed");
            $fatal(1, "No stimulus");
        end
        while (!$feof(fd) && n_lines < MAX_LINES) begin
            code = $fscanf(fd, "%h %h %h %h %h %h %h", pat_sof[n_lines], pat_dr[n_lines],
                           pat_deact[n_lines], pat_rgb[n_lines], pat_ovl[n_lines],
                           pat_report[n_lines], pat_mask[n_lines]);
            if (code == 7) begin
                n_lines++;
            end else if (code != -1) begin
                // Comment line, drop the rest of it
                code = $fgets(skip_buf, fd);
            end
        end
        $fclose(fd);
        if (n_lines == 0) begin
            $display("The patterns file holds no pattern lines");
            $display("Checks failed");
            $fatal(1, "No stimulus");
        end
        patterns_loaded = 1'b1;

        repeat (4) @(posedge clk);
        resetN <= 1'b1;

        // Drive pixel i, then check pixel i-1 mid-cycle
        for (int i = 0; i <= n_lines; i++) begin
            @(posedge clk);
            if (i < n_lines) begin
                apply_line(i);
            end else begin
                apply_idle();
            end
            if (i > 0) begin
                @(negedge clk);
                verify_line(i - 1);
            end
        end

        $display("All checks passed");
        $finish;
    end

    // Watchdog, sized from the pattern count plus reset and drain
    initial begin
        wait (patterns_loaded);
        #((n_lines + 20) * CLK_PERIOD);
        $display("Timeout: the patterns did not finish in time");
        $display("Checks failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

//--- list.f
hw/draw_pkg.sv
hw/overlap_if.sv
hw/check_overlap.sv
hw/draw_priority_mux.sv
hw/collision_tracker.sv
hw/frame_control.sv
hw/object_draw_top.sv
testbench/object_draw_checker.sv
testbench/object_draw_tb.sv

//--- testbench/draw_patterns.txt
# sof draw_request deactivated | expected rgb_out overlap report collision_mask
# all fields hex, expected values appear one clock after the pixel is sampled
0 0 0 49 0 0 0
0 1 0 E0 0 0 0
1 0 0 49 0 0 0
0 3 0 E0 1 0 0
0 C 0 03 1 0 0
0 2 2 49 0 0 0
0 6 2 03 0 0 0
0 0 0 49 0 0 0
1 0 0 49 0 1 F
0 8 0 FC 0 0 0
0 9 1 FC 0 0 0
0 0 0 49 0 0 0
1 0 0 49 0 1 0
0 7 2 E0 1 0 0
0 0 0 49 0 0 0
0 3 0 E0 1 0 0
1 C 0 03 1 1 7
0 F F 49 0 0 0
0 4 0 03 0 0 0
0 0 0 49 0 0 0
1 0 0 49 0 1 C
0 F 0 E0 1 0 0
0 F 1 1C 1 0 0
1 0 0 49 0 1 F
